// ==== vlog.f ====
+incdir+verif
src/l1_cache_pkg.sv
src/cache_ctrl.sv
src/cache_array.sv
src/mem_port.sv
src/l1_cache.sv
verif/l1_cache_tb.sv

// ==== Makefile ====
# Verilator build and run of the L1 data cache testbench

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = l1_cache_tb
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/cache_tests.svh ====
/*
 * directed tests for the L1 data cache, included in the testbench module
 *   xorshift generator, memory and reference helpers, compare tasks
 *   processor access tasks and the five test tasks
 */

`ifndef CACHE_TESTS_SVH
`define CACHE_TESTS_SVH

function automatic l1_cache_pkg::word_t xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// contents of never-written memory, spread over the whole address
function automatic l1_cache_pkg::word_t fill_value(input l1_cache_pkg::word_t addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A5A_5A5A;
endfunction

function automatic l1_cache_pkg::word_t mem_word(input l1_cache_pkg::word_t addr);
    return mem.exists(addr) ? mem[addr] : fill_value(addr);
endfunction

function automatic l1_cache_pkg::word_t ref_word(input l1_cache_pkg::word_t addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : fill_value(addr);
endfunction

// bytes, halves and the full word are honoured, any other value writes all four bytes
function automatic l1_cache_pkg::word_t write_mask(input l1_cache_pkg::byte_en_t be);
    l1_cache_pkg::word_t m;
    m = '1;
    if (be inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100})
        for (int b = 0; b < 4; b++)
            m[8*b +: 8] = {8{be[b]}};
    return m;
endfunction

function automatic void store_block(input l1_cache_pkg::word_t addr,
                                    input l1_cache_pkg::word_t [BLOCK_SIZE-1:0] blk,
                                    input logic [4*BLOCK_SIZE-1:0] be);
    l1_cache_pkg::word_t w;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
        w = mem_word(addr + 4*i);
        for (int b = 0; b < 4; b++)
            if (be[4*i+b])
                w[8*b +: 8] = blk[i][8*b +: 8];
        mem[addr + 4*i] = w;
    end
endfunction

task automatic check_word(input l1_cache_pkg::word_t got, input l1_cache_pkg::word_t exp,
                          input string what);
    checks++;
    if (got !== exp) begin
        word_errors++;
        $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
        flag_errors++;
        $display("FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
endtask

// one processor request, held until a cycle with proc_busy low
task automatic proc_access(input logic wr, input l1_cache_pkg::word_t addr,
                           input l1_cache_pkg::word_t data, input l1_cache_pkg::byte_en_t be,
                           output l1_cache_pkg::word_t rdata);
    @(negedge CLK);
    proc_ren     = !wr;
    proc_wen     = wr;
    proc_addr    = addr;
    proc_wdata   = data;
    proc_byte_en = be;
    @(posedge CLK);
    while (proc_busy)
        @(posedge CLK);
    rdata = proc_rdata;     // valid in the completing cycle
    @(negedge CLK);
    proc_ren = 1'b0;
    proc_wen = 1'b0;
endtask

task automatic write_word(input l1_cache_pkg::word_t addr, input l1_cache_pkg::word_t data,
                          input l1_cache_pkg::byte_en_t be);
    l1_cache_pkg::word_t unused;
    proc_access(1'b1, addr, data, be, unused);
    ref_mem[addr] = (ref_word(addr) & ~write_mask(be)) | (data & write_mask(be));
endtask

task automatic read_and_check(input l1_cache_pkg::word_t addr, input string what);
    l1_cache_pkg::word_t got;
    proc_access(1'b0, addr, '0, 4'b1111, got);
    check_word(got, ref_word(addr), what);
endtask

task automatic init_read_test();
    l1_cache_pkg::word_t addr;
    check_flag(mem_ren, 1'b0, "mem_ren low after reset");
    check_flag(mem_wen, 1'b0, "mem_wen low after reset");
    check_flag(flush_done, 1'b0, "flush_done low after reset");
    check_flag(proc_busy, 1'b1, "proc_busy high during the init sweep");
    addr          = xorshift32() & 32'h0FFF_FFFC;
    mem[addr]     = xorshift32();   // preload
    ref_mem[addr] = mem[addr];
    read_and_check(addr, "read miss after init");
    read_and_check(addr, "read hit of the same word");
endtask

task automatic byte_write_test();
    l1_cache_pkg::byte_en_t encs [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                         4'b0011, 4'b1100, 4'b0101};
    l1_cache_pkg::word_t    addr;
    addr = xorshift32() & 32'h0FFF_FFFC;
    read_and_check(addr, "allocate for byte writes");
    foreach (encs[i]) begin
        write_word(addr, xorshift32(), encs[i]);
        read_and_check(addr, $sformatf("read back after byte enable %b", encs[i]));
    end
endtask

task automatic dirty_evict_test();
    l1_cache_pkg::word_t addr, other;
    addr  = xorshift32() & 32'h0FFF_FFFC;
    other = addr ^ 32'h0000_0400;   // same set, other tag
    write_word(addr, xorshift32(), 4'b1111);
    read_and_check(other, "read of the conflicting address");
    check_word(mem_word(addr), ref_word(addr), "victim written back");
endtask

task automatic flush_test();
    l1_cache_pkg::word_t addrs [4];
    l1_cache_pkg::word_t base;
    int                  reads_before;
    base = xorshift32() & 32'h0FFF_FF80;
    foreach (addrs[i]) begin
        addrs[i] = base | ((i * 3 + 1) << 3) | ((i & 1) << 2);  // four distinct sets
        write_word(addrs[i], xorshift32(), 4'b1111);
    end
    @(negedge CLK);
    flush = 1'b1;
    @(negedge CLK);
    flush = 1'b0;
    @(posedge CLK);
    while (!flush_done)
        @(posedge CLK);
    @(posedge CLK);
    check_flag(flush_done, 1'b0, "flush_done is a single pulse");
    foreach (addrs[i])
        check_word(mem_word(addrs[i]), ref_word(addrs[i]), "memory updated by flush");
    foreach (addrs[i]) begin
        reads_before = mem_reads;
        read_and_check(addrs[i], "read after flush");
        check_flag(mem_reads != reads_before, 1'b1, "read after flush refills from memory");
    end
endtask

task automatic passthru_test();
    l1_cache_pkg::word_t addr, data;
    int                  lane;
    for (int k = 0; k < BLOCK_SIZE; k++) begin
        addr = 32'hF000_0000 | (xorshift32() & 32'h0FFF_FFF8) | (k << 2);
        data = xorshift32();
        lane = (addr >> 2) % BLOCK_SIZE;
        write_word(addr, data, 4'b1100);
        check_word(mem_word(addr), ref_word(addr), "pass-through write in memory");
        for (int j = 0; j < BLOCK_SIZE; j++)
            check_word(last_wdata[j], (j == lane) ? (data & write_mask(4'b1100)) : '0,
                       $sformatf("pass-through write data, lane %0d", j));
        read_and_check(addr, "pass-through read");
        mem[addr]     = xorshift32();   // changed behind the cache
        ref_mem[addr] = mem[addr];
        read_and_check(addr, "pass-through read not allocated");
    end
endtask

`endif

// ==== verif/l1_cache_tb.sv ====
/*
 * testbench for the L1 data cache
 *   clock, reset, DUT and a block memory model with fixed latency
 *   cycle timeout, error counts and the final status
 */

`timescale 1ns/100ps

module l1_cache_tb;
    localparam CACHE_SIZE  = 1024;
    localparam BLOCK_SIZE  = 2;
    localparam MEM_LATENCY = 3;     // busy cycles before a transfer completes
    localparam MAX_CYCLES  = 4000;  // the tests need about 300 cycles

    logic                                   CLK, nRST;
    logic                                   proc_ren, proc_wen, flush;
    l1_cache_pkg::word_t                    proc_addr, proc_wdata, proc_rdata;
    l1_cache_pkg::byte_en_t                 proc_byte_en;
    logic                                   proc_busy, flush_done;
    logic                                   mem_ren, mem_wen, mem_busy;
    l1_cache_pkg::word_t                    mem_addr;
    l1_cache_pkg::word_t [BLOCK_SIZE-1:0]   mem_wdata, mem_rdata;
    l1_cache_pkg::word_t [BLOCK_SIZE-1:0]   last_wdata;    // last block the cache wrote
    logic [4*BLOCK_SIZE-1:0]                mem_byte_en;

    l1_cache_pkg::word_t    mem [l1_cache_pkg::word_t];     // model contents, word aligned
    l1_cache_pkg::word_t    ref_mem [l1_cache_pkg::word_t]; // expected contents
    l1_cache_pkg::word_t    rng_state;
    int                     wait_cnt, cycles;
    int                     mem_reads;                      // completed read transfers
    int                     checks, word_errors, flag_errors;

    `include "cache_tests.svh"

    l1_cache #(
        .CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE),
        .NONCACHE_START_ADDR(32'hF000_0000)
    ) l1_cache_i (
        .CLK(CLK), .nRST(nRST),
        .proc_ren(proc_ren), .proc_wen(proc_wen), .proc_addr(proc_addr),
        .proc_wdata(proc_wdata), .proc_byte_en(proc_byte_en), .flush(flush),
        .proc_rdata(proc_rdata), .proc_busy(proc_busy), .flush_done(flush_done),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_byte_en(mem_byte_en),
        .mem_rdata(mem_rdata), .mem_busy(mem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // memory model, samples on the rising edge and answers on the falling edge
    initial begin
        mem_busy  = 1'b1;
        mem_rdata = '0;
        mem_reads = 0;
        forever begin
            @(posedge CLK);
            if (mem_ren || mem_wen) begin
                if (!mem_busy) begin    // transfer completes this cycle
                    if (mem_wen) begin
                        store_block(mem_addr, mem_wdata, mem_byte_en);
                        last_wdata = mem_wdata;
                    end
                    if (mem_ren)
                        mem_reads++;
                    wait_cnt = 0;
                end else begin
                    wait_cnt++;
                end
            end else begin
                wait_cnt = 0;
            end
            @(negedge CLK);
            mem_busy = (wait_cnt != MEM_LATENCY);
            if (!mem_busy)
                for (int i = 0; i < BLOCK_SIZE; i++)
                    mem_rdata[i] = mem_word(mem_addr + 4*i);
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        nRST         = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        flush        = 1'b0;
        rng_state    = 32'd54;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        init_read_test();
        byte_write_test();
        dirty_evict_test();
        flush_test();
        passthru_test();

        $display("checks %0d, word errors %0d, flag errors %0d",
                 checks, word_errors, flag_errors);
        if (word_errors + flag_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== src/l1_cache.sv ====
/*
 * L1 data cache top level, direct mapped, write back
 *   geometry derived from CACHE_SIZE (bits) and BLOCK_SIZE (words)
 *   controller, tag/data array and memory-bus port
 */

`timescale 1ns/100ps

module l1_cache #(
    parameter CACHE_SIZE          = 1024,
    parameter BLOCK_SIZE          = 2,
    parameter NONCACHE_START_ADDR = 32'hF000_0000
) (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic                                    proc_ren,
    input  logic                                    proc_wen,
    input  l1_cache_pkg::word_t                     proc_addr,
    input  l1_cache_pkg::word_t                     proc_wdata,
    input  l1_cache_pkg::byte_en_t                  proc_byte_en,
    input  logic                                    flush,
    output l1_cache_pkg::word_t                     proc_rdata,
    output logic                                    proc_busy,
    output logic                                    flush_done,
    output logic                                    mem_ren,
    output logic                                    mem_wen,
    output l1_cache_pkg::word_t                     mem_addr,
    output l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    mem_wdata,
    output logic [4*BLOCK_SIZE-1:0]                 mem_byte_en,
    input  l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    mem_rdata,
    input  logic                                    mem_busy
);
    localparam N_SETS       = CACHE_SIZE / (l1_cache_pkg::WORD_SIZE * BLOCK_SIZE);
    localparam N_SET_BITS   = $clog2(N_SETS) + (N_SETS == 1);
    localparam N_BLOCK_BITS = $clog2(BLOCK_SIZE) + (BLOCK_SIZE == 1);
    localparam N_TAG_BITS   = l1_cache_pkg::WORD_SIZE - N_SET_BITS - N_BLOCK_BITS
                              - l1_cache_pkg::BYTE_OFFSET_BITS;
    localparam SET_LSB      = N_BLOCK_BITS + l1_cache_pkg::BYTE_OFFSET_BITS;

    logic [N_SET_BITS-1:0]                  flush_set, set_sel;
    logic                                   use_flush_set, write_hit, fill, invalidate;
    logic                                   latch_req, uncached, hit;
    logic                                   victim_valid, victim_dirty;
    logic [N_TAG_BITS-1:0]                  victim_tag;
    l1_cache_pkg::word_t [BLOCK_SIZE-1:0]   victim_block;
    l1_cache_pkg::word_t                    rdata_word;
    l1_cache_pkg::word_t                    pending_addr;
    l1_cache_pkg::mem_mode_t                mem_mode;

    // sweep counter during init/flush, request index otherwise
    assign set_sel = use_flush_set ? flush_set : proc_addr[SET_LSB +: N_SET_BITS];

    always_ff @(posedge CLK) begin
        if (latch_req)
            pending_addr <= proc_addr;  // miss address for the fill
    end

    cache_ctrl #(.N_SETS(N_SETS), .N_SET_BITS(N_SET_BITS)) cache_ctrl_i (
        .CLK(CLK), .nRST(nRST),
        .proc_ren(proc_ren), .proc_wen(proc_wen), .flush(flush),
        .uncached(uncached), .hit(hit),
        .victim_valid(victim_valid), .victim_dirty(victim_dirty), .mem_busy(mem_busy),
        .proc_busy(proc_busy), .flush_done(flush_done),
        .state_sel_set(flush_set), .use_flush_set(use_flush_set),
        .write_hit(write_hit), .fill(fill), .invalidate(invalidate),
        .latch_req(latch_req), .mem_mode(mem_mode)
    );

    cache_array #(
        .N_SETS(N_SETS), .BLOCK_SIZE(BLOCK_SIZE), .N_SET_BITS(N_SET_BITS),
        .N_BLOCK_BITS(N_BLOCK_BITS), .N_TAG_BITS(N_TAG_BITS)
    ) cache_array_i (
        .CLK(CLK), .nRST(nRST), .set_sel(set_sel),
        .req_tag(proc_addr[l1_cache_pkg::WORD_SIZE-1 -: N_TAG_BITS]),
        .word_sel(proc_addr[l1_cache_pkg::BYTE_OFFSET_BITS +: N_BLOCK_BITS]),
        .wdata(proc_wdata), .byte_en(proc_byte_en), .fill_block(mem_rdata),
        .write_hit(write_hit), .fill(fill), .invalidate(invalidate),
        .hit(hit), .rdata_word(rdata_word),
        .victim_valid(victim_valid), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .victim_block(victim_block)
    );

    mem_port #(
        .BLOCK_SIZE(BLOCK_SIZE), .N_SET_BITS(N_SET_BITS), .N_BLOCK_BITS(N_BLOCK_BITS),
        .N_TAG_BITS(N_TAG_BITS), .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) mem_port_i (
        .mem_mode(mem_mode), .proc_addr(proc_addr), .pending_addr(pending_addr),
        .set_sel(set_sel), .proc_wdata(proc_wdata), .proc_byte_en(proc_byte_en),
        .proc_ren(proc_ren), .proc_wen(proc_wen),
        .victim_tag(victim_tag), .victim_block(victim_block),
        .cache_rdata(rdata_word), .mem_rdata(mem_rdata),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_byte_en(mem_byte_en),
        .proc_rdata(proc_rdata), .uncached(uncached)
    );

endmodule

// ==== src/mem_port.sv ====
/*
 * memory-bus request builder
 *   block fill and writeback addresses, pass-through word in its block lane
 *   read data routing to the processor
 */

`timescale 1ns/100ps

module mem_port #(
    parameter BLOCK_SIZE          = 2,
    parameter N_SET_BITS          = 4,
    parameter N_BLOCK_BITS        = 1,
    parameter N_TAG_BITS          = 25,
    parameter NONCACHE_START_ADDR = 32'hF000_0000
) (
    input  l1_cache_pkg::mem_mode_t                 mem_mode,
    input  l1_cache_pkg::word_t                     proc_addr,
    input  l1_cache_pkg::word_t                     pending_addr,
    input  logic [N_SET_BITS-1:0]                   set_sel,
    input  l1_cache_pkg::word_t                     proc_wdata,
    input  l1_cache_pkg::byte_en_t                  proc_byte_en,
    input  logic                                    proc_ren,
    input  logic                                    proc_wen,
    input  logic [N_TAG_BITS-1:0]                   victim_tag,
    input  l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    victim_block,
    input  l1_cache_pkg::word_t                     cache_rdata,
    input  l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    mem_rdata,
    output logic                                    mem_ren,
    output logic                                    mem_wen,
    output l1_cache_pkg::word_t                     mem_addr,
    output l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    mem_wdata,
    output logic [4*BLOCK_SIZE-1:0]                 mem_byte_en,
    output l1_cache_pkg::word_t                     proc_rdata,
    output logic                                    uncached
);
    localparam SET_LSB = N_BLOCK_BITS + l1_cache_pkg::BYTE_OFFSET_BITS;

    logic [N_BLOCK_BITS-1:0]    lane;
    l1_cache_pkg::word_t        mask;

    assign uncached = proc_addr >= NONCACHE_START_ADDR;
    assign lane     = proc_addr[l1_cache_pkg::BYTE_OFFSET_BITS +: N_BLOCK_BITS];
    assign mask     = l1_cache_pkg::lane_mask(proc_byte_en);

    always_comb begin
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        mem_byte_en = '1;   // whole block for fills and writebacks
        case (mem_mode)
            l1_cache_pkg::MEM_FILL: begin
                mem_ren  = 1'b1;
                mem_addr = {pending_addr[l1_cache_pkg::WORD_SIZE-1:SET_LSB], {SET_LSB{1'b0}}};
            end
            l1_cache_pkg::MEM_WB: begin
                mem_wen   = 1'b1;
                mem_addr  = {victim_tag, set_sel, {SET_LSB{1'b0}}};
                mem_wdata = victim_block;
            end
            l1_cache_pkg::MEM_PASS: begin
                // block-aligned address, word rides in its own lane
                mem_ren     = proc_ren;
                mem_wen     = proc_wen;
                mem_addr    = {proc_addr[l1_cache_pkg::WORD_SIZE-1:SET_LSB], {SET_LSB{1'b0}}};
                mem_byte_en = '0;
                mem_byte_en[4*lane +: 4] = {mask[24], mask[16], mask[8], mask[0]};
                mem_wdata[lane]          = proc_wdata & mask;   // unused bytes zero
            end
            default: ;
        endcase
    end

    assign proc_rdata = uncached ? mem_rdata[lane] : cache_rdata;

endmodule

// ==== src/cache_array.sv ====
/*
 * tag and data storage, one frame per set
 *   asynchronous read and tag compare
 *   masked word write on hit, block write on fill, invalidate
 */

`timescale 1ns/100ps

module cache_array #(
    parameter N_SETS       = 16,
    parameter BLOCK_SIZE   = 2,
    parameter N_SET_BITS   = 4,
    parameter N_BLOCK_BITS = 1,
    parameter N_TAG_BITS   = 25
) (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic [N_SET_BITS-1:0]                   set_sel,
    input  logic [N_TAG_BITS-1:0]                   req_tag,
    input  logic [N_BLOCK_BITS-1:0]                 word_sel,
    input  l1_cache_pkg::word_t                     wdata,
    input  l1_cache_pkg::byte_en_t                  byte_en,
    input  l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    fill_block,
    input  logic                                    write_hit,
    input  logic                                    fill,
    input  logic                                    invalidate,
    output logic                                    hit,
    output l1_cache_pkg::word_t                     rdata_word,
    output logic                                    victim_valid,
    output logic                                    victim_dirty,
    output logic [N_TAG_BITS-1:0]                   victim_tag,
    output l1_cache_pkg::word_t [BLOCK_SIZE-1:0]    victim_block
);
    logic [N_SETS-1:0]                      valid, dirty;
    logic [N_TAG_BITS-1:0]                  tag_mem [N_SETS];
    l1_cache_pkg::word_t [BLOCK_SIZE-1:0]   data_mem [N_SETS];
    l1_cache_pkg::word_t                    mask, merged;

    assign victim_valid = valid[set_sel];
    assign victim_dirty = dirty[set_sel];
    assign victim_tag   = tag_mem[set_sel];
    assign victim_block = data_mem[set_sel];
    assign rdata_word   = data_mem[set_sel][word_sel];
    assign hit          = victim_valid && (victim_tag == req_tag);

    assign mask   = l1_cache_pkg::lane_mask(byte_en);
    assign merged = (rdata_word & ~mask) | (wdata & mask);  // keep disabled lanes

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
        end else if (invalidate) begin
            valid[set_sel] <= 1'b0;
            dirty[set_sel] <= 1'b0;
        end else if (fill) begin
            valid[set_sel] <= 1'b1;
            dirty[set_sel] <= 1'b0;     // a pending store dirties it on replay
        end else if (write_hit) begin
            dirty[set_sel] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) begin
            tag_mem[set_sel]  <= req_tag;
            data_mem[set_sel] <= fill_block;
        end else if (write_hit) begin
            data_mem[set_sel][word_sel] <= merged;
        end
    end

    // invalidate is only raised by init/flush, fill only by a miss
    assert property (@(posedge CLK) disable iff (!nRST) !(invalidate && fill));

endmodule

// ==== src/cache_ctrl.sv ====
/*
 * cache controller FSM
 *   init sweep, hit/miss/pass-through decision, writeback and fill
 *   flush walk with pending-flush latch
 */

`timescale 1ns/100ps

module cache_ctrl #(
    parameter N_SETS     = 16,
    parameter N_SET_BITS = 4
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    proc_ren,
    input  logic                    proc_wen,
    input  logic                    flush,
    input  logic                    uncached,
    input  logic                    hit,
    input  logic                    victim_valid,
    input  logic                    victim_dirty,
    input  logic                    mem_busy,
    output logic                    proc_busy,
    output logic                    flush_done,
    output logic [N_SET_BITS-1:0]   state_sel_set,
    output logic                    use_flush_set,
    output logic                    write_hit,
    output logic                    fill,
    output logic                    invalidate,
    output logic                    latch_req,
    output l1_cache_pkg::mem_mode_t mem_mode
);
    typedef enum logic [2:0] {
        INIT,
        HIT,
        WB,
        FETCH,
        FLUSH
    } state_t;

    state_t                 state, next_state;
    logic [N_SET_BITS-1:0]  set_cnt, next_set_cnt;
    logic                   flush_pend, next_flush_pend;
    logic                   req, last_set, victim_wb;

    assign req           = proc_ren || proc_wen;
    assign last_set      = set_cnt == N_SET_BITS'(N_SETS - 1);
    assign victim_wb     = victim_valid && victim_dirty;
    assign state_sel_set = set_cnt;
    assign use_flush_set = (state == INIT) || (state == FLUSH);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= INIT;
            set_cnt    <= '0;
            flush_pend <= 1'b0;
        end else begin
            state      <= next_state;
            set_cnt    <= next_set_cnt;
            flush_pend <= next_flush_pend;
        end
    end

    // a flush seen while busy is kept until the walk starts
    always_comb begin
        next_flush_pend = flush_pend;
        if (state == FLUSH)
            next_flush_pend = 1'b0;
        else if (flush && state != HIT)
            next_flush_pend = 1'b1;
    end

    always_comb begin
        next_state   = state;
        next_set_cnt = set_cnt;
        proc_busy    = 1'b1;
        flush_done   = 1'b0;
        write_hit    = 1'b0;
        fill         = 1'b0;
        invalidate   = 1'b0;
        latch_req    = 1'b0;
        mem_mode     = l1_cache_pkg::MEM_IDLE;

        case (state)
            INIT: begin
                invalidate   = 1'b1;    // one set per cycle
                next_set_cnt = set_cnt + 1'b1;
                if (last_set) begin
                    next_set_cnt = '0;
                    next_state   = HIT;
                end
            end
            HIT: begin
                if (flush || flush_pend) begin
                    next_state = FLUSH;
                end else if (req && uncached) begin
                    mem_mode  = l1_cache_pkg::MEM_PASS;
                    proc_busy = mem_busy;
                end else if (req && hit) begin
                    proc_busy = 1'b0;
                    write_hit = proc_wen;
                end else if (req) begin
                    latch_req  = 1'b1;
                    next_state = victim_wb ? WB : FETCH;
                end
            end
            WB: begin
                mem_mode = l1_cache_pkg::MEM_WB;
                if (!mem_busy)
                    next_state = FETCH;
            end
            FETCH: begin
                mem_mode = l1_cache_pkg::MEM_FILL;
                if (!mem_busy) begin
                    fill       = 1'b1;
                    next_state = HIT;   // access replays as a hit
                end
            end
            FLUSH: begin
                if (victim_wb)
                    mem_mode = l1_cache_pkg::MEM_WB;
                if (!victim_wb || !mem_busy) begin
                    invalidate   = 1'b1;
                    next_set_cnt = set_cnt + 1'b1;
                    if (last_set) begin
                        flush_done   = 1'b1;
                        next_set_cnt = '0;
                        next_state   = HIT;
                    end
                end
            end
            default: next_state = INIT;
        endcase
    end

    // a replayed write must not land in the same cycle as its fill
    assert property (@(posedge CLK) disable iff (!nRST) !(write_hit && fill));

    // processor never asks for a read and a write at once on the pass-through path
    assert property (@(posedge CLK) disable iff (!nRST)
        mem_mode == l1_cache_pkg::MEM_PASS |-> !(proc_ren && proc_wen));

    assert property (@(posedge CLK) !nRST |=> state == INIT);

endmodule

// ==== src/l1_cache_pkg.sv ====
/*
 * shared definitions for the L1 data cache
 *   word and byte-enable types, memory-bus mode encoding
 *   lane_mask: byte enable to bit mask for partial writes
 */

package l1_cache_pkg;

    parameter int WORD_SIZE        = 32;
    parameter int BYTE_OFFSET_BITS = 2;

    typedef logic [WORD_SIZE-1:0] word_t;
    typedef logic [3:0]           byte_en_t;

    // what the memory bus is doing this cycle
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_FILL,   // block read for a miss
        MEM_WB,     // block write of a dirty victim
        MEM_PASS    // single word, uncached
    } mem_mode_t;

    // only bytes, halves and the full word are legal; anything else is a word write
    function automatic word_t lane_mask(input byte_en_t byte_en);
        case (byte_en)
            4'b0001: lane_mask = 32'h0000_00FF;
            4'b0010: lane_mask = 32'h0000_FF00;
            4'b0100: lane_mask = 32'h00FF_0000;
            4'b1000: lane_mask = 32'hFF00_0000;
            4'b0011: lane_mask = 32'h0000_FFFF;
            4'b1100: lane_mask = 32'hFFFF_0000;
            default: lane_mask = '1;
        endcase
    endfunction

endpackage
